// ==== hw/vga_timing_pkg.sv ====
package vga_timing_pkg;

    //////////////////////////////////////////////////////////////////////
    // screen timing, every field counted in clocks (h_*) or lines (v_*)
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [11:0] h_sync;    // hsync pulse width
        logic [11:0] h_back;    // back porch
        logic [11:0] h_left;    // left border
        logic [11:0] h_valid;   // visible pixels per line
        logic [11:0] h_right;   // right border
        logic [11:0] h_front;   // front porch
        logic [11:0] h_total;   // full line period
        logic [11:0] v_sync;    // vsync pulse width
        logic [11:0] v_back;
        logic [11:0] v_top;     // top border
        logic [11:0] v_valid;   // visible lines per frame
        logic [11:0] v_bottom;
        logic [11:0] v_total;   // full frame period, front porch is the remainder
    } vga_timing_t;

    // standard 640x480 at 60 Hz with a 25 MHz pixel clock
    localparam vga_timing_t VGA_640X480 = '{
        h_sync:   12'd96,
        h_back:   12'd40,
        h_left:   12'd8,
        h_valid:  12'd640,
        h_right:  12'd8,
        h_front:  12'd8,
        h_total:  12'd800,
        v_sync:   12'd2,
        v_back:   12'd25,
        v_top:    12'd8,
        v_valid:  12'd480,
        v_bottom: 12'd8,
        v_total:  12'd525       // leaves 2 lines of front porch
    };

    // wave memory read port, driven by the timing generator
    typedef struct packed {
        logic       en;         // one clock per sample fetched
        logic [9:0] addr;       // sample index along the trace
    } wave_rd_t;

endpackage

// ==== hw/wave_pkg.sv ====
package wave_pkg;

    //////////////////////////////////////////////////////////////////////
    // sample and pixel types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  sample_t;      // value = screen row, 0 at top
    typedef logic [15:0] rgb565_t;      // r5 g6 b5

    localparam rgb565_t COLOR_TRACE = 16'hFFE0;    // yellow
    localparam rgb565_t COLOR_GRID  = 16'h0410;    // dark green
    localparam rgb565_t COLOR_BACK  = 16'h0000;    // black

    //////////////////////////////////////////////////////////////////////
    // capture side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CAP_IDLE,               // back bank free, nothing pending
        CAP_FILL,               // storing incoming samples
        CAP_DONE                // full trace waiting for frame end
    } cap_state_e;

    // write port into the back bank
    typedef struct packed {
        logic       en;
        logic [9:0] addr;
        sample_t    data;
    } wave_wr_t;

endpackage

// ==== hw/wave_capture.sv ====
module wave_capture #(
    parameter int WAVE_LEN = 300
) (
    input  logic               vga_clk,
    input  logic               sys_rst_n,
    input  logic               arm,           // starts or restarts a fill
    input  logic               sample_valid,
    input  wave_pkg::sample_t  sample,
    input  logic               frame_end,     // last clock of the frame
    output wave_pkg::wave_wr_t wr,
    output logic               wr_bank,       // bank being written
    output logic               capture_busy
);
    import wave_pkg::*;

    localparam logic [9:0] LAST_IDX = 10'(WAVE_LEN - 1);

    cap_state_e state;
    logic [9:0] wr_idx;         // next slot to fill
    logic       wr_fire;        // sample accepted this clock

    // samples outside a fill are lost, an arm takes priority over a sample
    assign wr_fire = sample_valid && (state == CAP_FILL) && !arm;

    assign wr = '{en: wr_fire, addr: wr_idx, data: sample};

    assign capture_busy = (state != CAP_IDLE);

    //////////////////////////////////////////////////////////////////////
    // fill state machine and bank select
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= CAP_IDLE;
            wr_idx  <= '0;
            wr_bank <= 1'b0;
        end else begin
            case (state)
                CAP_IDLE: begin
                    if (arm) begin
                        state  <= CAP_FILL;
                        wr_idx <= '0;
                    end
                end
                CAP_FILL: begin
                    if (arm) begin
                        wr_idx <= '0;                   // restart from slot 0
                    end else if (wr_fire) begin
                        if (wr_idx == LAST_IDX) begin
                            state <= CAP_DONE;          // trace complete
                        end else begin
                            wr_idx <= wr_idx + 10'd1;
                        end
                    end
                end
                CAP_DONE: begin
                    if (arm) begin
                        state  <= CAP_FILL;             // throw away, refill
                        wr_idx <= '0;
                    end else if (frame_end) begin
                        wr_bank <= ~wr_bank;            // swap in blanking only
                        state   <= CAP_IDLE;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    // a write past the trace would land in a slot that is never drawn
    a_wr_in_range: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        wr.en |-> (wr.addr < WAVE_LEN)
    );

endmodule

// ==== hw/wave_ram.sv ====
module wave_ram (
    input  logic                     vga_clk,
    input  wave_pkg::wave_wr_t       wr,
    input  logic                     wr_bank,    // write side, read uses the other
    input  vga_timing_pkg::wave_rd_t rd,
    output wave_pkg::sample_t        rd_data     // valid one clock after rd.en
);
    import wave_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // two banks, one written while the other is displayed
    //////////////////////////////////////////////////////////////////////

    sample_t bank0 [1024];
    sample_t bank1 [1024];

    // write port into the back bank
    always_ff @(posedge vga_clk) begin
        if (wr.en) begin
            if (wr_bank) begin
                bank1[wr.addr] <= wr.data;
            end else begin
                bank0[wr.addr] <= wr.data;
            end
        end
    end

    // registered read from the front bank, holds between bursts
    always_ff @(posedge vga_clk) begin
        if (rd.en) begin
            if (wr_bank) begin
                rd_data <= bank0[rd.addr];
            end else begin
                rd_data <= bank1[rd.addr];
            end
        end
    end

    // the capture side swaps at frame end, which the timing generator
    // places in vertical blanking, so a read burst never straddles a swap
    a_swap_outside_read: assert property (
        @(posedge vga_clk)
        (rd.en || $past(rd.en)) |-> $stable(wr_bank)
    );

endmodule

// ==== hw/vga_ctrl.sv ====
module vga_ctrl #(
    parameter vga_timing_pkg::vga_timing_t TIMING   = vga_timing_pkg::VGA_640X480,
    parameter int                          WAVE_LEN = 300
) (
    input  logic                     vga_clk,
    input  logic                     sys_rst_n,
    input  wave_pkg::rgb565_t        pix_data,   // colour for the current pixel
    output logic                     pix_req,    // one clock ahead of rgb_valid
    output logic [11:0]              pix_x,
    output logic [11:0]              pix_y,
    output vga_timing_pkg::wave_rd_t rd,         // two clocks ahead of the pixel
    output logic                     frame_end,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     rgb_valid,
    output wave_pkg::rgb565_t        rgb
);
    //////////////////////////////////////////////////////////////////////
    // window edges from the timing struct
    //////////////////////////////////////////////////////////////////////

    localparam int H_ACT    = TIMING.h_sync + TIMING.h_back + TIMING.h_left;
    localparam int H_END    = H_ACT + TIMING.h_valid;      // first count past the line
    localparam int V_ACT    = TIMING.v_sync + TIMING.v_back + TIMING.v_top;
    localparam int V_END    = V_ACT + TIMING.v_valid;
    localparam int RD_START = H_ACT - 2;                   // memory + render latency
    localparam int RD_END   = RD_START + WAVE_LEN;
    localparam int H_LAST   = TIMING.h_total - 1;
    localparam int V_LAST   = TIMING.v_total - 1;

    if (WAVE_LEN > TIMING.h_valid || WAVE_LEN > 1024) begin : g_len_check
        $error("WAVE_LEN does not fit the visible line or the wave memory");
    end

    logic [11:0] cnt_h;         // clock within line
    logic [11:0] cnt_v;         // line within frame
    logic [11:0] h_nxt;
    logic [11:0] v_nxt;
    logic        line_act;      // next line is visible
    logic        valid_nxt;
    logic        req_nxt;
    logic        rd_en_nxt;

    //////////////////////////////////////////////////////////////////////
    // counters, outputs are registered from the next count so they line
    // up with the counters and stay low in reset
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        h_nxt = cnt_h + 12'd1;
        v_nxt = cnt_v;
        if (cnt_h == 12'(H_LAST)) begin
            h_nxt = 12'd0;                                  // line wrap
            v_nxt = (cnt_v == 12'(V_LAST)) ? 12'd0 : cnt_v + 12'd1;
        end
    end

    assign line_act  = (v_nxt >= V_ACT) && (v_nxt < V_END);
    assign valid_nxt = line_act && (h_nxt >= H_ACT) && (h_nxt < H_END);
    assign req_nxt   = line_act && (h_nxt >= H_ACT - 1) && (h_nxt < H_END - 1);
    assign rd_en_nxt = line_act && (h_nxt >= RD_START) && (h_nxt < RD_END);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_h     <= '0;
            cnt_v     <= '0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            rgb_valid <= 1'b0;
            pix_req   <= 1'b0;
            pix_x     <= 12'hfff;
            pix_y     <= 12'hfff;
            rd        <= '0;
            frame_end <= 1'b0;
        end else begin
            cnt_h     <= h_nxt;
            cnt_v     <= v_nxt;
            hsync     <= (h_nxt < TIMING.h_sync);
            vsync     <= (v_nxt < TIMING.v_sync);
            rgb_valid <= valid_nxt;
            pix_req   <= req_nxt;
            pix_x     <= req_nxt ? h_nxt - 12'(H_ACT - 1) : 12'hfff;  // fff off window
            pix_y     <= req_nxt ? v_nxt - 12'(V_ACT) : 12'hfff;
            rd.en     <= rd_en_nxt;
            rd.addr   <= rd_en_nxt ? 10'(h_nxt - 12'(RD_START)) : 10'd0;
            frame_end <= (h_nxt == 12'(H_LAST)) && (v_nxt == 12'(V_LAST));
        end
    end

    // blank outside the visible window
    assign rgb = rgb_valid ? pix_data : '0;

    // render result is only meaningful for pixels that were requested
    a_valid_after_req: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        rgb_valid |-> $past(pix_req)
    );

endmodule

// ==== hw/wave_render.sv ====
module wave_render #(
    parameter int GRID_STEP = 32
) (
    input  logic              vga_clk,
    input  logic              sys_rst_n,
    input  logic              rd_en,      // sample fetch strobe from timing
    input  wave_pkg::sample_t rd_data,    // one clock after rd_en
    input  logic              pix_req,
    input  logic [11:0]       pix_x,
    input  logic [11:0]       pix_y,
    output wave_pkg::rgb565_t pix_data    // one clock after pix_req
);
    import wave_pkg::*;

    localparam int GRID_BITS = $clog2(GRID_STEP);

    if (GRID_STEP < 2 || (GRID_STEP & (GRID_STEP - 1)) != 0) begin : g_step_check
        $error("GRID_STEP must be a power of two of at least 2");
    end

    logic    rd_en_d;       // rd_data belongs to the column in pix_x
    logic    trace_hit;
    logic    grid_hit;
    rgb565_t color_nxt;

    //////////////////////////////////////////////////////////////////////
    // stage 1: realign the fetch strobe with the memory output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_en_d <= 1'b0;
        end else begin
            rd_en_d <= rd_en;   // low past WAVE_LEN, no trace there
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: colour pick and output register
    //////////////////////////////////////////////////////////////////////

    assign trace_hit = rd_en_d && (pix_y == {4'd0, rd_data});  // row match
    assign grid_hit  = (pix_x[GRID_BITS-1:0] == '0)
                    || (pix_y[GRID_BITS-1:0] == '0);

    always_comb begin
        if (!pix_req) begin
            color_nxt = COLOR_BACK;     // not shown anyway
        end else if (trace_hit) begin
            color_nxt = COLOR_TRACE;    // trace wins over grid
        end else if (grid_hit) begin
            color_nxt = COLOR_GRID;
        end else begin
            color_nxt = COLOR_BACK;
        end
    end

    always_ff @(posedge vga_clk) begin
        pix_data <= color_nxt;
    end

endmodule

// ==== hw/wave_display_top.sv ====
module wave_display_top #(
    parameter vga_timing_pkg::vga_timing_t TIMING    = vga_timing_pkg::VGA_640X480,
    parameter int                          WAVE_LEN  = 300,   // samples per trace
    parameter int                          GRID_STEP = 32     // grid pitch in pixels
) (
    input  logic              vga_clk,
    input  logic              sys_rst_n,
    input  logic              arm,
    input  logic              sample_valid,
    input  wave_pkg::sample_t sample,
    output logic              hsync,
    output logic              vsync,
    output logic              rgb_valid,
    output wave_pkg::rgb565_t rgb,
    output logic              capture_busy
);
    import vga_timing_pkg::*;
    import wave_pkg::*;

    wave_wr_t    wr;
    logic        wr_bank;
    wave_rd_t    rd;
    sample_t     rd_data;
    rgb565_t     pix_data;
    logic        pix_req;
    logic [11:0] pix_x;
    logic [11:0] pix_y;
    logic        frame_end;

    //////////////////////////////////////////////////////////////////////
    // capture -> memory -> render -> timing
    //////////////////////////////////////////////////////////////////////

    wave_capture #(
        .WAVE_LEN    (WAVE_LEN)
    ) wave_capture_inst (
        .vga_clk     (vga_clk),
        .sys_rst_n   (sys_rst_n),
        .arm         (arm),
        .sample_valid(sample_valid),
        .sample      (sample),
        .frame_end   (frame_end),
        .wr          (wr),
        .wr_bank     (wr_bank),
        .capture_busy(capture_busy)
    );

    wave_ram wave_ram_inst (
        .vga_clk (vga_clk),
        .wr      (wr),
        .wr_bank (wr_bank),
        .rd      (rd),
        .rd_data (rd_data)
    );

    wave_render #(
        .GRID_STEP(GRID_STEP)
    ) wave_render_inst (
        .vga_clk  (vga_clk),
        .sys_rst_n(sys_rst_n),
        .rd_en    (rd.en),
        .rd_data  (rd_data),
        .pix_req  (pix_req),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .pix_data (pix_data)
    );

    vga_ctrl #(
        .TIMING   (TIMING),
        .WAVE_LEN (WAVE_LEN)
    ) vga_ctrl_inst (
        .vga_clk  (vga_clk),
        .sys_rst_n(sys_rst_n),
        .pix_data (pix_data),
        .pix_req  (pix_req),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .rd       (rd),
        .frame_end(frame_end),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb_valid(rgb_valid),
        .rgb      (rgb)
    );

endmodule

// ==== testbench/tb_wave_display.sv ====
module tb_wave_display;
    import vga_timing_pkg::*;
    import wave_pkg::*;

    // tiny screen so a frame is only 924 clocks
    localparam vga_timing_t TB_TIMING = '{
        h_sync: 12'd4, h_back: 12'd2, h_left: 12'd1, h_valid: 12'd32, h_right: 12'd1,
        h_front: 12'd2, h_total: 12'd42,
        v_sync: 12'd1, v_back: 12'd2, v_top: 12'd1, v_valid: 12'd16, v_bottom: 12'd1,
        v_total: 12'd22
    };
    localparam int WAVE_LEN   = 24;
    localparam int GRID_STEP  = 8;
    localparam int H_TOTAL    = 42;
    localparam int FRAME_CLKS = 924;      // 42 x 22
    localparam int H_ACT      = 7;        // sync + back + left
    localparam int V_ACT      = 4;
    localparam int X_PIX      = 32;
    localparam int Y_PIX      = 16;
    localparam int N_ROWS     = 5;
    localparam int TIMEOUT    = N_ROWS * 4 * FRAME_CLKS;
    localparam int PAT_RAMP   = 0;        // k mod 16
    localparam int PAT_CONST  = 1;        // row 5
    localparam int PAT_RAND   = 2;        // below 16
    localparam int PAT_OFF    = 3;        // 200, below the screen

    //////////////////////////////////////////////////////////////////////
    // test table: name, pattern, samples fed after the last arm, rearm
    //////////////////////////////////////////////////////////////////////

    string test_name  [N_ROWS] = '{"ramp", "constant", "random", "off_screen", "restart"};
    int    test_pat   [N_ROWS] = '{PAT_RAMP, PAT_CONST, PAT_RAND, PAT_OFF, PAT_RAMP};
    int    test_fed   [N_ROWS] = '{28, 24, 30, 24, 26};   // extras past 24 get dropped
    bit    test_rearm [N_ROWS] = '{0, 0, 0, 0, 1};

    logic    vga_clk;
    logic    sys_rst_n;
    logic    arm;
    logic    sample_valid;
    sample_t sample;
    logic    hsync;
    logic    vsync;
    logic    rgb_valid;
    rgb565_t rgb;
    logic    capture_busy;

    int      errors = 0;
    int      cycles = 0;
    int      vs_gap = 0;
    int      vs_rises = 0;
    logic    vs_prev = 1'b0;
    bit      have_old;
    sample_t new_wave [WAVE_LEN];     // being captured
    sample_t ref_wave [WAVE_LEN];     // expected on screen

    wave_display_top #(
        .TIMING      (TB_TIMING),
        .WAVE_LEN    (WAVE_LEN),
        .GRID_STEP   (GRID_STEP)
    ) wave_display_top_inst (
        .vga_clk     (vga_clk),
        .sys_rst_n   (sys_rst_n),
        .arm         (arm),
        .sample_valid(sample_valid),
        .sample      (sample),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb_valid   (rgb_valid),
        .rgb         (rgb),
        .capture_busy(capture_busy)
    );

    always #4 vga_clk = ~vga_clk;

    function automatic sample_t pattern_value(int pat, int k);
        case (pat)
            PAT_RAMP:  return sample_t'(k % 16);
            PAT_CONST: return 8'd5;
            PAT_RAND:  return sample_t'($urandom_range(15, 0));
            default:   return 8'd200;
        endcase
    endfunction

    // trace first, then grid lines, then black
    function automatic rgb565_t expected_color(int x, int y);
        if (x < WAVE_LEN && ref_wave[x] == y) return COLOR_TRACE;
        if (x % GRID_STEP == 0 || y % GRID_STEP == 0) return COLOR_GRID;
        return COLOR_BACK;
    endfunction

    task automatic pulse_arm();
        @(posedge vga_clk);
        #1 arm = 1'b1;
        @(posedge vga_clk);
        #1 arm = 1'b0;
    endtask

    task automatic feed_sample(sample_t value);
        repeat ($urandom_range(3, 0)) @(posedge vga_clk);     // idle gap
        @(posedge vga_clk);
        #1;
        sample_valid = 1'b1;
        sample       = value;
        @(posedge vga_clk);
        #1 sample_valid = 1'b0;
    endtask

    task automatic run_capture(int row);
        pulse_arm();
        if (test_rearm[row]) begin
            repeat (10) feed_sample(sample_t'($urandom_range(15, 0)));   // thrown away
            pulse_arm();
        end
        for (int k = 0; k < test_fed[row]; k++) begin
            feed_sample(k < WAVE_LEN ? new_wave[k] : pattern_value(test_pat[row], k));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one frame from clock 0, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    task automatic check_frame(string tag);
        int      h;
        int      v;
        int      n_valid;
        logic    exp_valid;
        rgb565_t exp_rgb;
        n_valid = 0;
        for (int i = 0; i < FRAME_CLKS; i++) begin
            h         = i % H_TOTAL;
            v         = i / H_TOTAL;
            exp_valid = (v >= V_ACT) && (v < V_ACT + Y_PIX) && (h >= H_ACT) && (h < H_ACT + X_PIX);
            exp_rgb   = exp_valid ? expected_color(h - H_ACT, v - V_ACT) : 16'h0000;
            if (hsync !== (h < 4)) begin
                errors++;
                $display("FAIL %s: hsync line %0d clk %0d expected %0b actual %0b",
                         tag, v, h, (h < 4), hsync);
            end
            if (vsync !== (v < 1)) begin
                errors++;
                $display("FAIL %s: vsync line %0d clk %0d expected %0b actual %0b",
                         tag, v, h, (v < 1), vsync);
            end
            if (rgb_valid !== exp_valid) begin
                errors++;
                $display("FAIL %s: rgb_valid line %0d clk %0d expected %0b actual %0b",
                         tag, v, h, exp_valid, rgb_valid);
            end
            if (rgb !== exp_rgb) begin
                errors++;
                $display("FAIL %s: rgb line %0d clk %0d expected %h actual %h",
                         tag, v, h, exp_rgb, rgb);
            end
            if (rgb_valid === 1'b1) n_valid++;
            @(negedge vga_clk);
        end
        if (n_valid != X_PIX * Y_PIX) begin
            errors++;
            $display("FAIL %s: active pixels expected %0d actual %0d", tag, X_PIX * Y_PIX, n_valid);
        end
    endtask

    // frame period between vsync rises, the first gap after reset is short
    always @(negedge vga_clk) begin
        vs_gap++;
        if (vsync === 1'b1 && vs_prev === 1'b0) begin
            if (vs_rises >= 2 && vs_gap != FRAME_CLKS) begin
                errors++;
                $display("FAIL vsync_period: expected %0d actual %0d", FRAME_CLKS, vs_gap);
            end
            vs_gap = 0;
            vs_rises++;
        end
        vs_prev = vsync;
    end

    always @(posedge vga_clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d clocks, capture or frame never finished, %0d errors",
                     cycles, errors);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        vga_clk      = 1'b0;
        sys_rst_n    = 1'b0;
        arm          = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        have_old     = 1'b0;
        void'($urandom(32'h73d648b4));
        repeat (3) @(posedge vga_clk);
        #1 sys_rst_n = 1'b1;
        @(negedge vsync);                 // skip the partial frame after reset
        @(posedge vsync);
        @(negedge vga_clk);               // clock 0 of a full frame
        for (int row = 0; row < N_ROWS; row++) begin
            for (int k = 0; k < WAVE_LEN; k++) begin
                new_wave[k] = pattern_value(test_pat[row], k);
            end
            // fill ends well inside this frame, so it still shows old data
            fork
                run_capture(row);
                if (have_old) check_frame({test_name[row], " while filling"});
            join
            // the first row joins mid-frame and still waits for the swap
            if (capture_busy !== !have_old) begin
                errors++;
                $display("FAIL %s: capture_busy expected %0b actual %0b",
                         test_name[row], !have_old, capture_busy);
            end
            while (capture_busy) @(negedge vga_clk);
            ref_wave = new_wave;
            check_frame(test_name[row]);
            have_old = 1'b1;
        end
        $display("summary: %0d errors over %0d tests", errors, N_ROWS);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hw/vga_timing_pkg.sv
hw/wave_pkg.sv
hw/wave_capture.sv
hw/wave_ram.sv
hw/vga_ctrl.sv
hw/wave_render.sv
hw/wave_display_top.sv
testbench/tb_wave_display.sv
